// File: common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// register width, sets every data, pc and address port
`define RV_XLEN 32

// mstatus bit positions
`define MSTATUS_MIE  3   // global machine interrupt enable
`define MSTATUS_MPIE 7   // MIE saved on trap entry

// major opcodes, instr[6:0]
`define OPC_SYSTEM 7'b1110011   // csr, ecall, ebreak, mret
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

// privileged funct12 encodings under funct3 zero
`define F12_ECALL  12'h000
`define F12_EBREAK 12'h001
`define F12_MRET   12'h302

`endif

// File: common/rv_pkg.sv
package rv_pkg;

    // funct3 of the SYSTEM opcode, value 4 is reserved
    typedef enum logic [2:0] {
        CSR_PRIV = 3'd0,   // ecall, ebreak, mret
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_RWI  = 3'd5,
        CSR_RSI  = 3'd6,
        CSR_RCI  = 3'd7
    } csr_op_t;

    // implemented machine CSRs only
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344
    } csr_addr_t;

    // load/store funct3, unsigned forms share alignment with signed
    typedef enum logic [2:0] {
        MEM_B  = 3'd0,
        MEM_H  = 3'd1,
        MEM_W  = 3'd2,
        MEM_D  = 3'd3,   // rv64 only
        MEM_BU = 3'd4,
        MEM_HU = 3'd5,
        MEM_WU = 3'd6    // rv64 only
    } mem_width_t;

    // mcause exception codes, interrupt bit never set here
    typedef enum logic [3:0] {
        CAUSE_FETCH_MISALIGN = 4'd0,
        CAUSE_ILLEGAL        = 4'd2,
        CAUSE_BREAKPOINT     = 4'd3,
        CAUSE_LOAD_MISALIGN  = 4'd4,
        CAUSE_STORE_MISALIGN = 4'd6,
        CAUSE_ECALL_M        = 4'd11
    } trap_cause_t;

endpackage

// File: csr/misalign_detector.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module misalign_detector (
    input  logic               is_load,
    input  logic               is_store,
    input  rv_pkg::mem_width_t mem_width,
    input  logic [2:0]         addr_low,
    input  logic [1:0]         pc_low,
    output logic               fetch_misaligned,
    output logic               load_misaligned,
    output logic               store_misaligned
);
    import rv_pkg::*;

    logic half_bad;     // halfword on odd byte
    logic word_bad;     // word off 4-byte boundary
    logic dword_bad;    // doubleword off 8-byte boundary
    logic access_bad;

    // bytes never misalign, so MEM_B/MEM_BU fall through
    assign half_bad = ((mem_width == MEM_H) || (mem_width == MEM_HU)) && addr_low[0];
    assign word_bad = ((mem_width == MEM_W) || (mem_width == MEM_WU))
                      && (addr_low[1:0] != 2'b00);

    generate
        if (`RV_XLEN == 64) begin : g_dword
            assign dword_bad = (mem_width == MEM_D) && (addr_low != 3'b000);
        end else begin : g_no_dword
            assign dword_bad = 1'b0;   // no doubleword access on rv32
        end
    endgenerate

    assign access_bad = half_bad || word_bad || dword_bad;

    assign load_misaligned  = is_load && access_bad;
    assign store_misaligned = is_store && access_bad;

    // no compressed support, any low pc bit is a fault
    assign fetch_misaligned = (pc_low != 2'b00);

endmodule

// File: src/system_decoder.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module system_decoder (
    input  logic                valid,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] rs1_value,
    output logic                is_csr,
    output logic                csr_write,
    output logic                is_ecall,
    output logic                is_ebreak,
    output logic                is_mret,
    output logic                is_illegal,
    output logic                is_load,
    output logic                is_store,
    output rv_pkg::csr_op_t     csr_op,
    output rv_pkg::csr_addr_t   csr_addr,
    output rv_pkg::mem_width_t  mem_width,
    output logic [`RV_XLEN-1:0] operand
);
    import rv_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;     // also zimm for immediate forms
    logic [4:0]  rd_field;
    logic [11:0] funct12;       // csr address or priv encoding
    logic        sys_op;
    logic        csr_form;
    logic        priv_form;
    logic        addr_hit;
    logic        regs_zero;

    assign opcode    = instr[6:0];
    assign rd_field  = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];
    assign funct12   = instr[31:20];

    assign sys_op    = valid && (opcode == `OPC_SYSTEM);
    assign is_load   = valid && (opcode == `OPC_LOAD);
    assign is_store  = valid && (opcode == `OPC_STORE);
    assign mem_width = mem_width_t'(funct3);   // only looked at for loads/stores

    assign csr_form  = (funct3 != 3'd0) && (funct3 != 3'd4);
    assign priv_form = (funct3 == 3'd0);
    assign regs_zero = (rs1_field == 5'd0) && (rd_field == 5'd0);

    always_comb begin
        case (funct3)
            3'd1:    csr_op = CSR_RW;
            3'd2:    csr_op = CSR_RS;
            3'd3:    csr_op = CSR_RC;
            3'd5:    csr_op = CSR_RWI;
            3'd6:    csr_op = CSR_RSI;
            3'd7:    csr_op = CSR_RCI;
            default: csr_op = CSR_PRIV;   // 0, and reserved 4
        endcase
    end

    // match against the eight implemented machine CSRs
    always_comb begin
        addr_hit = 1'b1;
        case (funct12)
            12'h300: csr_addr = CSR_MSTATUS;
            12'h304: csr_addr = CSR_MIE;
            12'h305: csr_addr = CSR_MTVEC;
            12'h340: csr_addr = CSR_MSCRATCH;
            12'h341: csr_addr = CSR_MEPC;
            12'h342: csr_addr = CSR_MCAUSE;
            12'h343: csr_addr = CSR_MTVAL;
            12'h344: csr_addr = CSR_MIP;
            default: begin
                csr_addr = CSR_MSTATUS;   // don't care, flagged illegal
                addr_hit = 1'b0;
            end
        endcase
    end

    assign is_csr    = sys_op && csr_form && addr_hit;
    assign is_ecall  = sys_op && priv_form && regs_zero && (funct12 == `F12_ECALL);
    assign is_ebreak = sys_op && priv_form && regs_zero && (funct12 == `F12_EBREAK);
    assign is_mret   = sys_op && priv_form && regs_zero && (funct12 == `F12_MRET);

    assign is_illegal = sys_op && ((funct3 == 3'd4)
                                   || (csr_form && !addr_hit)
                                   || (priv_form && !(is_ecall || is_ebreak || is_mret)));

    // rw forms always write, set/clear only with a nonzero source
    assign csr_write = is_csr && ((funct3[1:0] == 2'b01) || (rs1_field != 5'd0));
    assign operand   = funct3[2] ? `RV_XLEN'(rs1_field) : rs1_value;   // zimm zero-extended

    always_comb begin
        assert ($onehot0({is_csr, is_ecall, is_ebreak, is_mret}))
            else $error("system_decoder: more than one instruction class decoded");
    end

endmodule

// File: csr/csr_file.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module csr_file (
    input  logic                clock,
    input  logic                reset,
    input  logic                is_csr,
    input  logic                csr_write,
    input  logic                is_ecall,
    input  logic                is_ebreak,
    input  logic                is_mret,
    input  logic                is_illegal,
    input  logic                is_load,
    input  logic                is_store,
    input  rv_pkg::csr_op_t     csr_op,
    input  rv_pkg::csr_addr_t   csr_addr,
    input  rv_pkg::mem_width_t  mem_width,
    input  logic [`RV_XLEN-1:0] operand,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] mem_addr,
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] rd_data,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] mstatus;
    logic [`RV_XLEN-1:0] mie;        // plain storage, no interrupts
    logic [`RV_XLEN-1:0] mip;        // plain storage, no interrupts
    logic [`RV_XLEN-1:0] mtvec;      // direct mode only
    logic [`RV_XLEN-1:0] mepc;
    logic [`RV_XLEN-1:0] mcause;
    logic [`RV_XLEN-1:0] mtval;
    logic [`RV_XLEN-1:0] mscratch;

    logic [`RV_XLEN-1:0] old_value;  // addressed csr before the op
    logic [`RV_XLEN-1:0] new_value;
    logic [`RV_XLEN-1:0] trap_value;
    trap_cause_t         trap_cause;
    logic                fetch_misaligned;
    logic                load_misaligned;
    logic                store_misaligned;
    logic                active;
    logic                take_trap;
    logic                csr_we;

    misalign_detector u_misalign (
        .is_load          (is_load),
        .is_store         (is_store),
        .mem_width        (mem_width),
        .addr_low         (mem_addr[2:0]),
        .pc_low           (pc[1:0]),
        .fetch_misaligned (fetch_misaligned),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    // only decoded system/load/store instructions can trap, others pass through
    assign active = is_csr || is_ecall || is_ebreak || is_mret || is_illegal
                    || is_load || is_store;

    assign take_trap = is_illegal || (active && fetch_misaligned) || is_ecall
                       || is_ebreak || store_misaligned || load_misaligned;
    assign csr_we = csr_write && !take_trap;   // trapped csr op does not retire

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:  old_value = mstatus;
            CSR_MIE:      old_value = mie;
            CSR_MTVEC:    old_value = mtvec;
            CSR_MSCRATCH: old_value = mscratch;
            CSR_MEPC:     old_value = mepc;
            CSR_MCAUSE:   old_value = mcause;
            CSR_MTVAL:    old_value = mtval;
            CSR_MIP:      old_value = mip;
            default:      old_value = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            CSR_RW, CSR_RWI: new_value = operand;                  // replace
            CSR_RS, CSR_RSI: new_value = old_value | operand;      // set bits
            CSR_RC, CSR_RCI: new_value = old_value & ~operand;     // clear bits
            default:         new_value = old_value;
        endcase
    end

    // fixed priority, highest first
    always_comb begin
        if (is_illegal)
            trap_cause = CAUSE_ILLEGAL;
        else if (active && fetch_misaligned)
            trap_cause = CAUSE_FETCH_MISALIGN;
        else if (is_ecall)
            trap_cause = CAUSE_ECALL_M;
        else if (is_ebreak)
            trap_cause = CAUSE_BREAKPOINT;
        else if (store_misaligned)
            trap_cause = CAUSE_STORE_MISALIGN;
        else
            trap_cause = CAUSE_LOAD_MISALIGN;   // also idle value, unused then
    end

    always_comb begin
        case (trap_cause)
            CAUSE_ILLEGAL:        trap_value = `RV_XLEN'(instr);   // faulting word
            CAUSE_LOAD_MISALIGN:  trap_value = mem_addr;
            CAUSE_STORE_MISALIGN: trap_value = mem_addr;
            default:              trap_value = '0;
        endcase
    end

    assign rd_data     = is_csr ? old_value : '0;
    assign redirect    = take_trap || is_mret;
    assign redirect_pc = take_trap ? {mtvec[`RV_XLEN-1:2], 2'b00} : mepc;

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end else if (take_trap) begin
            mepc                  <= pc;
            mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
            mstatus[`MSTATUS_MIE]  <= 1'b0;
            mcause                <= `RV_XLEN'(trap_cause);
            mtval                 <= trap_value;
        end else if (is_mret) begin
            mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
            mstatus[`MSTATUS_MPIE] <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS:  mstatus  <= new_value;
                CSR_MIE:      mie      <= new_value;
                CSR_MTVEC:    mtvec    <= new_value;
                CSR_MSCRATCH: mscratch <= new_value;
                CSR_MEPC:     mepc     <= new_value;
                CSR_MCAUSE:   mcause   <= new_value;
                CSR_MTVAL:    mtval    <= new_value;
                CSR_MIP:      mip      <= new_value;
                default:      ;
            endcase
        end
    end

    // pipeline must hold valid low in reset
    no_redirect_in_reset: assert property (@(posedge clock) reset |-> !redirect)
        else $error("csr_file: redirect during reset");

    // registers outside trap entry stay untouched across a trap
    trap_no_csr_write: assert property (@(posedge clock) disable iff (reset)
        take_trap |=> ($stable(mscratch) && $stable(mtvec) && $stable(mie) && $stable(mip)))
        else $error("csr_file: csr written in a trap cycle");

endmodule

// File: src/system_stage.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module system_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_value,
    input  logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] rd_data,      // old csr value
    output logic                redirect,     // trap or mret this cycle
    output logic [`RV_XLEN-1:0] redirect_pc
);
    import rv_pkg::*;

    logic                is_csr;
    logic                csr_write;
    logic                is_ecall;
    logic                is_ebreak;
    logic                is_mret;
    logic                is_illegal;
    logic                is_load;
    logic                is_store;
    csr_op_t             csr_op;
    csr_addr_t           csr_addr;
    mem_width_t          mem_width;
    logic [`RV_XLEN-1:0] operand;     // rs1 or zimm

    system_decoder u_decoder (
        .valid      (valid),
        .instr      (instr),
        .rs1_value  (rs1_value),
        .is_csr     (is_csr),
        .csr_write  (csr_write),
        .is_ecall   (is_ecall),
        .is_ebreak  (is_ebreak),
        .is_mret    (is_mret),
        .is_illegal (is_illegal),
        .is_load    (is_load),
        .is_store   (is_store),
        .csr_op     (csr_op),
        .csr_addr   (csr_addr),
        .mem_width  (mem_width),
        .operand    (operand)
    );

    csr_file u_csr (
        .clock       (clock),
        .reset       (reset),
        .is_csr      (is_csr),
        .csr_write   (csr_write),
        .is_ecall    (is_ecall),
        .is_ebreak   (is_ebreak),
        .is_mret     (is_mret),
        .is_illegal  (is_illegal),
        .is_load     (is_load),
        .is_store    (is_store),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .mem_width   (mem_width),
        .operand     (operand),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .instr       (instr),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: tb/tb_system_stage.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_system_stage;
    import rv_pkg::*;

    localparam int RESET_TIMEOUT = 20;   // cycles allowed for reset release

    logic                clock;
    logic                reset;
    logic                valid;
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_value;
    logic [`RV_XLEN-1:0] mem_addr;
    logic [`RV_XLEN-1:0] rd_data;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    // stimulus table, one entry per cycle
    logic                tbl_valid[$];
    logic [31:0]         tbl_instr[$];
    logic [`RV_XLEN-1:0] tbl_pc[$];
    logic [`RV_XLEN-1:0] tbl_rs1[$];
    logic [`RV_XLEN-1:0] tbl_addr[$];

    // reference csrs: mstatus mie mtvec mscratch mepc mcause mtval mip
    logic [`RV_XLEN-1:0] model_csr[0:7];
    logic [31:0]         rng;
    logic                reset_ok;
    int data_errors;
    int redirect_errors;
    int cause_errors;
    int timeout_errors;

    system_stage uut (
        .clock       (clock),
        .reset       (reset),
        .valid       (valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_value   (rs1_value),
        .mem_addr    (mem_addr),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] csr_word(input csr_op_t op, input logic [11:0] a,
                                             input logic [4:0] src, input logic [4:0] dst);
        return {a, src, 3'(op), dst, `OPC_SYSTEM};
    endfunction

    function automatic int csr_index(input logic [11:0] a);
        case (a)
            12'h300: return 0;
            12'h304: return 1;
            12'h305: return 2;
            12'h340: return 3;
            12'h341: return 4;
            12'h342: return 5;
            12'h343: return 6;
            12'h344: return 7;
            default: return -1;   // unimplemented
        endcase
    endfunction

    task automatic add_entry(input logic v, input logic [31:0] ins, input logic [31:0] p,
                             input logic [31:0] rs, input logic [31:0] ad);
        tbl_valid.push_back(v);
        tbl_instr.push_back(ins);
        tbl_pc.push_back(p);
        tbl_rs1.push_back(rs);
        tbl_addr.push_back(ad);
    endtask

    task automatic add_csr(input csr_op_t op, input logic [11:0] a, input logic [4:0] src,
                           input logic [31:0] rs);
        add_entry(1'b1, csr_word(op, a, src, 5'd1), 32'h40, rs, 32'h0);
    endtask

    // csrrs with x0, junk rs1 value must be ignored
    task automatic add_read(input csr_addr_t a);
        rng = xorshift32(rng);
        add_csr(CSR_RS, a, 5'd0, rng);
    endtask

    task automatic check_data(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            data_errors++;
        end
    endtask

    task automatic check_redirect(input logic got_r, input logic [`RV_XLEN-1:0] got_pc,
                                  input logic exp_r, input logic [`RV_XLEN-1:0] exp_pc);
        if (got_r !== exp_r) begin
            $display("** Error: redirect got 0x%h expected 0x%h at %0t", got_r, exp_r, $time);
            redirect_errors++;
        end else if (exp_r && got_pc !== exp_pc) begin
            $display("** Error: redirect_pc got 0x%h expected 0x%h at %0t",
                     got_pc, exp_pc, $time);
            redirect_errors++;
        end
    endtask

    task automatic check_cause(input trap_cause_t got, input trap_cause_t exp);
        if (got !== exp) begin
            $display("** Error: mcause got 0x%h expected 0x%h at %0t", got, exp, $time);
            cause_errors++;
        end
    endtask

    // expected outputs from current state, then state update for the next edge
    task automatic model_step(input logic v, input logic [31:0] ins,
                              input logic [`RV_XLEN-1:0] p, input logic [`RV_XLEN-1:0] rs,
                              input logic [`RV_XLEN-1:0] ad, output logic [`RV_XLEN-1:0] exp_rd,
                              output logic exp_redir, output logic [`RV_XLEN-1:0] exp_target);
        logic [2:0]          f3;
        logic [4:0]          src;
        logic [11:0]         f12;
        logic                sys, ld, st, csr_ok, ecall, ebreak, mret, illegal;
        logic                misal, fetch_bad, trap;
        int                  idx;
        logic [`RV_XLEN-1:0] old, opnd;
        trap_cause_t         cause;
        f3  = ins[14:12];
        src = ins[19:15];
        f12 = ins[31:20];
        sys = v && (ins[6:0] == `OPC_SYSTEM);
        ld  = v && (ins[6:0] == `OPC_LOAD);
        st  = v && (ins[6:0] == `OPC_STORE);
        idx = csr_index(f12);
        csr_ok = sys && (f3 != 3'd0) && (f3 != 3'd4) && (idx >= 0);
        ecall  = sys && (ins[19:7] == 13'd0) && (f12 == 12'h000);
        ebreak = sys && (ins[19:7] == 13'd0) && (f12 == 12'h001);
        mret   = sys && (ins[19:7] == 13'd0) && (f12 == 12'h302);
        illegal = sys && !csr_ok && !ecall && !ebreak && !mret;
        misal = ((f3[1:0] == 2'b01) && ad[0]) || ((f3[1:0] == 2'b10) && (ad[1:0] != 2'b00));
        fetch_bad = (sys || ld || st) && (p[1:0] != 2'b00);
        trap = illegal || fetch_bad || ecall || ebreak || ((ld || st) && misal);
        if (illegal) cause = CAUSE_ILLEGAL;
        else if (fetch_bad) cause = CAUSE_FETCH_MISALIGN;
        else if (ecall) cause = CAUSE_ECALL_M;
        else if (ebreak) cause = CAUSE_BREAKPOINT;
        else if (st) cause = CAUSE_STORE_MISALIGN;
        else cause = CAUSE_LOAD_MISALIGN;
        old = (idx >= 0) ? model_csr[idx] : '0;
        exp_rd = csr_ok ? old : '0;
        exp_redir = trap || mret;
        exp_target = trap ? {model_csr[2][`RV_XLEN-1:2], 2'b00} : model_csr[4];
        if (trap) begin
            model_csr[4] = p;
            model_csr[0][`MSTATUS_MPIE] = model_csr[0][`MSTATUS_MIE];
            model_csr[0][`MSTATUS_MIE] = 1'b0;
            model_csr[5] = `RV_XLEN'(cause);
            if (cause == CAUSE_ILLEGAL) model_csr[6] = `RV_XLEN'(ins);
            else if (cause == CAUSE_LOAD_MISALIGN || cause == CAUSE_STORE_MISALIGN)
                model_csr[6] = ad;
            else model_csr[6] = '0;
        end else if (mret) begin
            model_csr[0][`MSTATUS_MIE] = model_csr[0][`MSTATUS_MPIE];
            model_csr[0][`MSTATUS_MPIE] = 1'b1;
        end else if (csr_ok && ((f3[1:0] == 2'b01) || (src != 5'd0))) begin
            opnd = f3[2] ? `RV_XLEN'(src) : rs;   // zimm for immediate forms
            case (f3[1:0])
                2'b01:   model_csr[idx] = opnd;
                2'b10:   model_csr[idx] = old | opnd;
                default: model_csr[idx] = old & ~opnd;
            endcase
        end
    endtask

    task automatic build_table();
        add_csr(CSR_RW, CSR_MSCRATCH, 5'd5, 32'hdead_beef);
        add_csr(CSR_RS, CSR_MSCRATCH, 5'd6, 32'h0000_f0f0);
        add_csr(CSR_RC, CSR_MSCRATCH, 5'd7, 32'h0000_00ff);
        add_csr(CSR_RS, CSR_MSCRATCH, 5'd0, 32'hffff_ffff);   // x0 source, no write
        add_csr(CSR_RC, CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        add_csr(CSR_RWI, CSR_MSCRATCH, 5'd21, 32'h1234_5678);
        add_csr(CSR_RSI, CSR_MSCRATCH, 5'd10, 32'h0);
        add_csr(CSR_RCI, CSR_MSCRATCH, 5'd1, 32'h0);
        add_csr(CSR_RSI, CSR_MSCRATCH, 5'd0, 32'h0);
        add_csr(CSR_RCI, CSR_MSCRATCH, 5'd0, 32'h0);
        for (int k = 0; k < 4; k++) begin
            rng = xorshift32(rng);
            add_csr(CSR_RW, CSR_MSCRATCH, 5'd9, rng);
        end
        add_read(CSR_MSCRATCH);
        add_csr(CSR_RWI, CSR_MTVEC, 5'd3, 32'h0);
        add_csr(CSR_RW, CSR_MTVEC, 5'd3, 32'h0000_1003);   // low bits must be masked
        add_csr(CSR_RC, CSR_MTVEC, 5'd4, 32'h0000_0002);
        add_csr(CSR_RSI, CSR_MTVEC, 5'd16, 32'h0);
        add_csr(CSR_RCI, CSR_MTVEC, 5'd17, 32'h0);
        add_csr(CSR_RS, CSR_MTVEC, 5'd8, 32'h0000_0003);
        add_read(CSR_MTVEC);
        add_csr(CSR_RW, CSR_MTVAL, 5'd2, 32'h5555_aaaa);
        add_csr(CSR_RSI, CSR_MSTATUS, 5'd8, 32'h0);          // MIE on
        add_entry(1'b1, 32'h0000_0073, 32'h100, 32'h0, 32'h0);   // ecall
        add_read(CSR_MCAUSE);
        add_read(CSR_MEPC);
        add_read(CSR_MTVAL);
        add_read(CSR_MSTATUS);
        add_entry(1'b1, 32'h0010_0073, 32'h204, 32'h0, 32'h0);   // ebreak
        add_read(CSR_MCAUSE);
        add_read(CSR_MSTATUS);
        add_entry(1'b1, {12'h0, 5'd3, 3'd2, 5'd0, `OPC_LOAD}, 32'h300, 32'h0, 32'h1002);
        add_read(CSR_MCAUSE);
        add_read(CSR_MTVAL);
        add_entry(1'b1, {12'h0, 5'd2, 3'd1, 5'd0, `OPC_STORE}, 32'h304, 32'h0, 32'h2001);
        add_read(CSR_MCAUSE);
        add_entry(1'b1, {12'h0, 5'd2, 3'd2, 5'd0, `OPC_STORE}, 32'h308, 32'h0, 32'h2002);
        add_read(CSR_MTVAL);
        add_entry(1'b1, {12'h0, 5'd3, 3'd5, 5'd0, `OPC_LOAD}, 32'h30c, 32'h0, 32'h3003);
        add_read(CSR_MCAUSE);
        add_entry(1'b1, {12'h0, 5'd3, 3'd2, 5'd0, `OPC_LOAD}, 32'h310, 32'h0, 32'h4000);
        add_entry(1'b1, {12'h0, 5'd3, 3'd0, 5'd0, `OPC_LOAD}, 32'h314, 32'h0, 32'h4003);
        add_entry(1'b1, {12'h0, 5'd2, 3'd1, 5'd0, `OPC_STORE}, 32'h318, 32'h0, 32'h4002);
        add_read(CSR_MEPC);
        add_read(CSR_MTVAL);
        add_entry(1'b1, {12'h0, 5'd3, 3'd0, 5'd0, `OPC_LOAD}, 32'h302, 32'h0, 32'h10);
        add_read(CSR_MCAUSE);
        add_entry(1'b1, 32'h0000_0073, 32'h401, 32'h0, 32'h0);   // ecall, fetch fault wins
        add_read(CSR_MCAUSE);
        add_entry(1'b1, 32'h0010_0093, 32'h3, 32'h0, 32'h0);     // addi passes through
        add_entry(1'b1, csr_word(CSR_RW, CSR_MSCRATCH, 5'd5, 5'd1), 32'h2, 32'h77, 32'h0);
        add_read(CSR_MSCRATCH);
        add_read(CSR_MEPC);
        add_csr(CSR_RW, 12'h7c0, 5'd5, 32'h1);                   // unimplemented csr
        add_read(CSR_MCAUSE);
        add_read(CSR_MTVAL);
        add_entry(1'b1, {12'h340, 5'd1, 3'd4, 5'd2, `OPC_SYSTEM}, 32'h500, 32'h0, 32'h0);
        add_read(CSR_MTVAL);
        add_entry(1'b1, 32'h1050_0073, 32'h504, 32'h0, 32'h0);   // wfi not supported
        add_read(CSR_MCAUSE);
        add_csr(CSR_RW, CSR_MEPC, 5'd6, 32'h0000_0800);
        add_entry(1'b1, 32'h3020_0073, 32'h900, 32'h0, 32'h0);   // mret
        add_read(CSR_MSTATUS);
        add_csr(CSR_RW, CSR_MSTATUS, 5'd7, 32'h0000_0080);       // MPIE on, MIE off
        add_entry(1'b1, 32'h3020_0073, 32'h904, 32'h0, 32'h0);
        add_read(CSR_MSTATUS);
        add_entry(1'b0, csr_word(CSR_RW, CSR_MSCRATCH, 5'd5, 5'd1), 32'h40, 32'hffff, 32'h0);
        add_entry(1'b0, 32'h0000_0073, 32'h1, 32'h0, 32'h0);
        add_entry(1'b0, 32'h3020_0073, 32'h40, 32'h0, 32'h0);
        add_read(CSR_MSCRATCH);
        add_read(CSR_MCAUSE);
        add_read(CSR_MSTATUS);
    endtask

    task automatic wait_reset_release(output logic ok);
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        ok = (reset === 1'b0);
    endtask

    task automatic run_table();
        logic [`RV_XLEN-1:0] exp_rd;
        logic [`RV_XLEN-1:0] exp_target;
        logic                exp_redir;
        for (int i = 0; i < tbl_instr.size(); i++) begin
            @(posedge clock);
            valid     <= tbl_valid[i];
            instr     <= tbl_instr[i];
            pc        <= tbl_pc[i];
            rs1_value <= tbl_rs1[i];
            mem_addr  <= tbl_addr[i];
            @(negedge clock);   // outputs settled mid cycle
            model_step(tbl_valid[i], tbl_instr[i], tbl_pc[i], tbl_rs1[i], tbl_addr[i],
                       exp_rd, exp_redir, exp_target);
            check_data("rd_data", rd_data, exp_rd);
            check_redirect(redirect, redirect_pc, exp_redir, exp_target);
            if (tbl_valid[i] && tbl_instr[i] == csr_word(CSR_RS, CSR_MCAUSE, 5'd0, 5'd1))
                check_cause(trap_cause_t'(rd_data[3:0]), trap_cause_t'(exp_rd[3:0]));
        end
        @(posedge clock);
        valid <= 1'b0;
        @(posedge clock);
    endtask

    initial begin
        valid     = 1'b0;
        instr     = 32'h0000_0013;   // nop
        pc        = '0;
        rs1_value = '0;
        mem_addr  = '0;
        rng       = 32'd24604;
        data_errors = 0;
        redirect_errors = 0;
        cause_errors = 0;
        timeout_errors = 0;
        for (int k = 0; k < 8; k++) model_csr[k] = '0;
        build_table();
        wait_reset_release(reset_ok);
        if (!reset_ok) begin
            $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            timeout_errors++;
        end else begin
            run_table();
        end
        $display("errors: data=%0d redirect=%0d cause=%0d timeout=%0d",
                 data_errors, redirect_errors, cause_errors, timeout_errors);
        if (data_errors + redirect_errors + cause_errors + timeout_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: list.f
+incdir+common
common/rv_pkg.sv
csr/misalign_detector.sv
src/system_decoder.sv
csr/csr_file.sv
src/system_stage.sv
tb/tb_system_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_system_stage
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
